// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := axis_demux_tb
FILELIST  := axis_demux_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the run prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: axis_demux_top.f
source/axis_demux_pkg.sv
source/axis_rx_skid.sv
source/axis_route_lookup.sv
source/axis_tx_slice.sv
source/axis_demux_top.sv
dv/axis_demux_tb_clock.sv
dv/axis_demux_tb.sv

// File: dv/axis_demux_tb.sv
`timescale 1ns/10ps

/* Testbench for the AXI4-Stream demux. Random packets from a fixed seed,
 * a routing model with one queue of expected beats per output, six tests.
 */
module axis_demux_tb import axis_demux_pkg::*; ();
    localparam int OUTPUTS = 4;
    localparam int TIMEOUT = 2000;

    typedef struct packed {
        tdata_t data;
        tbyte_t keep;
        tbyte_t strb;
        logic   last;
        tdest_t dest;
        tuser_t user;
        tid_t   id;
    } beat_rec_t;

    logic                 aclk;
    logic                 reset;
    logic                 rx_tvalid;
    logic                 rx_tready;
    tdata_t               rx_tdata;
    tbyte_t               rx_tkeep;
    tbyte_t               rx_tstrb;
    logic                 rx_tlast;
    tdest_t               rx_tdest;
    tuser_t               rx_tuser;
    tid_t                 rx_tid;
    logic   [OUTPUTS-1:0] tx_tvalid;
    logic   [OUTPUTS-1:0] tx_tready;
    tdata_t [OUTPUTS-1:0] tx_tdata;
    tbyte_t [OUTPUTS-1:0] tx_tkeep;
    tbyte_t [OUTPUTS-1:0] tx_tstrb;
    logic   [OUTPUTS-1:0] tx_tlast;
    tdest_t [OUTPUTS-1:0] tx_tdest;
    tuser_t [OUTPUTS-1:0] tx_tuser;
    tid_t   [OUTPUTS-1:0] tx_tid;

    beat_rec_t exp_q[OUTPUTS][$];  // Expected beats per output, oldest first
    int        got_count[OUTPUTS];
    int        n_checks;
    int        n_errors;
    int        n_tests;
    int        test_err_base;
    int        stalls;
    bit        timed_out;
    bit        random_ready;
    string     cur_test;

    axis_demux_tb_clock u_clock (.aclk(aclk), .reset(reset));

    axis_demux_top dut (
        .aclk(aclk), .reset(reset),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep), .rx_tstrb(rx_tstrb), .rx_tlast(rx_tlast),
        .rx_tdest(rx_tdest), .rx_tuser(rx_tuser), .rx_tid(rx_tid),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tdata(tx_tdata),
        .tx_tkeep(tx_tkeep), .tx_tstrb(tx_tstrb), .tx_tlast(tx_tlast),
        .tx_tdest(tx_tdest), .tx_tuser(tx_tuser), .tx_tid(tx_tid)
    );

    task automatic check_data(tdata_t exp, tdata_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s tdata expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_bytes(string field, tbyte_t exp, tbyte_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s %s expected %h actual %h", cur_test, field, exp, act);
        end
    endtask

    task automatic check_user(tuser_t exp, tuser_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s tuser expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_dest(tdest_t exp, tdest_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s tdest expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_id(tid_t exp, tid_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s tid expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_flag(string field, logic exp, logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR %s %s expected %b actual %b", cur_test, field, exp, act);
        end
    endtask

    // Default table: value i+16 selects output i, anything else drops
    function automatic int predict_output(tuser_t user);
        for (int i = 0; i < OUTPUTS; i++) begin
            if (user == tuser_t'(i + 16)) return i;
        end
        return -1;
    endfunction

    function automatic tuser_t pick_user(bit routed_only);
        int sel;
        sel = routed_only ? int'($urandom_range(3, 0)) : int'($urandom_range(5, 0));
        if (sel == 4) return 8'd3;
        if (sel == 5) return 8'd40;
        return tuser_t'(16 + sel);
    endfunction

    task automatic check_beat(int k, beat_rec_t act);
        beat_rec_t exp;
        if (exp_q[k].size() == 0) begin
            n_errors++;
            $display("%s: output %0d sent a beat that nothing was routed to", cur_test, k);
        end else begin
            exp = exp_q[k].pop_front();
            got_count[k]++;
            check_data(exp.data, act.data);
            check_bytes("tkeep", exp.keep, act.keep);
            check_bytes("tstrb", exp.strb, act.strb);
            check_flag("tlast", exp.last, act.last);
            check_dest(exp.dest, act.dest);
            check_user(exp.user, act.user);
            check_id(exp.id, act.id);
        end
    endtask

    // Transfer happens at the next rising edge, values are settled here
    for (genvar k = 0; k < OUTPUTS; k++) begin : g_mon
        always @(negedge aclk) begin
            if (!reset && tx_tvalid[k] && tx_tready[k]) begin
                check_beat(k, {tx_tdata[k], tx_tkeep[k], tx_tstrb[k], tx_tlast[k],
                               tx_tdest[k], tx_tuser[k], tx_tid[k]});
            end
        end
    end

    task automatic drive_tx_ready();
        forever begin
            @(posedge aclk);
            #2;
            tx_tready = random_ready ? OUTPUTS'($urandom) : '1;
        end
    endtask

    task automatic send_beat(beat_rec_t b);
        int waited;
        rx_tvalid = 1'b1;
        {rx_tdata, rx_tkeep, rx_tstrb, rx_tlast, rx_tdest, rx_tuser, rx_tid} = b;
        waited = 0;
        @(negedge aclk);
        while (!rx_tready && !timed_out) begin
            stalls++;
            waited++;
            if (waited >= TIMEOUT) begin
                $display("%s: rx_tready stayed low for %0d cycles", cur_test, TIMEOUT);
                timed_out = 1'b1;
            end
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
    endtask

    // Route of the whole packet comes from the first beat
    task automatic send_packet(int beats, tuser_t first, bit mixed_user);
        beat_rec_t b;
        int        idx;
        idx = predict_output(first);
        for (int i = 0; i < beats && !timed_out; i++) begin
            b.data = tdata_t'($urandom);
            b.keep = tbyte_t'($urandom);
            b.strb = tbyte_t'($urandom);
            b.last = (i == beats - 1);
            b.dest = tdest_t'($urandom);
            b.id   = tid_t'($urandom);
            b.user = first;
            while (mixed_user && i > 0 && b.user == first) b.user = pick_user(1'b0);
            if (idx >= 0) exp_q[idx].push_back(b);
            send_beat(b);
        end
    endtask

    task automatic wait_drain();
        int waited;
        bit busy;
        waited = 0;
        busy   = 1'b1;
        rx_tvalid = 1'b0;
        while (busy && !timed_out) begin
            @(posedge aclk);
            busy = 1'b0;
            for (int k = 0; k < OUTPUTS; k++) begin
                if (exp_q[k].size() != 0) busy = 1'b1;
            end
            waited++;
            if (busy && waited >= TIMEOUT) begin
                $display("%s: outputs still owed beats after %0d cycles", cur_test, TIMEOUT);
                timed_out = 1'b1;
            end
        end
        #2;
    endtask

    task automatic start_test(string name);
        cur_test      = name;
        test_err_base = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == test_err_base) $display("%s: ok", cur_test);
        else $display("%s: %0d errors", cur_test, n_errors - test_err_base);
    endtask

    initial begin
        int waited;
        int got_before;
        void'($urandom(14));
        rx_tvalid = 1'b0;
        rx_tdata  = '0;
        rx_tkeep  = '0;
        rx_tstrb  = '0;
        rx_tlast  = 1'b0;
        rx_tdest  = '0;
        rx_tuser  = '0;
        rx_tid    = '0;
        tx_tready = '1;
        fork
            drive_tx_ready();
        join_none

        waited = 0;
        @(negedge aclk);
        while (reset && !timed_out) begin
            waited++;
            if (waited >= TIMEOUT) begin
                $display("reset never released");
                timed_out = 1'b1;
            end
            @(negedge aclk);
        end

        start_test("reset_state");
        for (int k = 0; k < OUTPUTS; k++) check_flag("tx_tvalid", 1'b0, tx_tvalid[k]);
        check_flag("rx_tready", 1'b1, rx_tready);
        end_test();
        @(posedge aclk);
        #2;

        start_test("routing");
        repeat (20) send_packet(int'($urandom_range(8, 1)), pick_user(1'b1), 1'b0);
        wait_drain();
        end_test();

        start_test("dropping");  // tuser 3 and 40 match nothing
        repeat (24) send_packet(int'($urandom_range(8, 1)), pick_user(1'b0), 1'b0);
        wait_drain();
        end_test();

        start_test("route_locking");
        repeat (12) send_packet(int'($urandom_range(8, 2)), pick_user(1'b1), 1'b1);
        wait_drain();
        end_test();

        start_test("backpressure");
        random_ready = 1'b1;
        repeat (30) send_packet(int'($urandom_range(8, 1)), pick_user(1'b0), 1'b0);
        wait_drain();
        random_ready = 1'b0;
        end_test();

        start_test("throughput");
        repeat (2) @(posedge aclk);  // Let tx_tready settle high again
        #2;
        stalls     = 0;
        got_before = got_count[1];
        send_packet(32, 8'd17, 1'b0);
        wait_drain();
        if (stalls != 0) begin
            n_errors++;
            $display("%s: rx_tready fell %0d times with no back-pressure", cur_test, stalls);
        end
        if (got_count[1] - got_before != 32) begin
            n_errors++;
            $display("ERR %s beat count expected 32 actual %0d", cur_test,
                     got_count[1] - got_before);
        end
        end_test();

        for (int k = 0; k < OUTPUTS; k++) begin
            if (exp_q[k].size() != 0) begin
                n_errors++;
                $display("output %0d still owes %0d beats at the end", k, exp_q[k].size());
            end
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/axis_demux_tb_clock.sv
`timescale 1ns/10ps

/* Clock and reset source for the demux testbench. 40 ns period,
 * reset high for the first 3 rising edges.
 */
module axis_demux_tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic aclk,
    output logic reset
);
    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD) aclk = ~aclk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2 reset = 1'b0;  // Same skew as the stimulus
    end

endmodule

// File: source/axis_demux_pkg.sv
/* Stream field widths, field types and the route FSM encoding for the demux.
 * Imported by every design module that uses one of these types.
 */
package axis_demux_pkg;

    localparam int TDATA_BYTES = 4;
    localparam int TUSER_WIDTH = 8;
    localparam int TID_WIDTH   = 4;
    localparam int TDEST_WIDTH = 4;

    // Largest table that map_default builds
    localparam int MAX_OUTPUTS = 16;

    typedef logic [TDATA_BYTES*8-1:0] tdata_t;
    typedef logic [TDATA_BYTES-1:0]   tbyte_t;  // tkeep and tstrb
    typedef logic [TUSER_WIDTH-1:0]   tuser_t;
    typedef logic [TID_WIDTH-1:0]     tid_t;
    typedef logic [TDEST_WIDTH-1:0]   tdest_t;

    // All payload fields of one beat packed together, tready and tvalid excluded
    localparam int BEAT_WIDTH = $bits(tdata_t) + 2 * $bits(tbyte_t) + 1
                              + $bits(tdest_t) + $bits(tuser_t) + $bits(tid_t);

    typedef logic [BEAT_WIDTH-1:0] beat_t;

    typedef enum logic [1:0] {
        ROUTE_IDLE,     // Waiting for the first beat of a packet
        ROUTE_FORWARD,  // Route locked to one output
        ROUTE_DROP      // Unmatched packet, beats consumed
    } route_state_t;

    // Entry i selects output i for field value i+16
    function automatic logic [MAX_OUTPUTS-1:0][TUSER_WIDTH-1:0] map_default();
        logic [MAX_OUTPUTS-1:0][TUSER_WIDTH-1:0] map;
        for (int i = 0; i < MAX_OUTPUTS; i++) begin
            map[i] = TUSER_WIDTH'(i + 16);
        end
        return map;
    endfunction

endpackage

// File: source/axis_demux_top.sv
`timescale 1ns/10ps

/* AXI4-Stream demux: one receive stream routed whole-packet to OUTPUTS
 * transmit streams. Skid buffer, route lookup and one slice per output.
 */
module axis_demux_top import axis_demux_pkg::*; #(
    parameter int OUTPUTS = 4,
    parameter int USE_TID = 0,
    parameter logic [OUTPUTS-1:0][TUSER_WIDTH-1:0] MAP =
        (OUTPUTS * TUSER_WIDTH)'(map_default())
) (
    input  logic                 aclk,
    input  logic                 reset,
    // Receive stream
    input  logic                 rx_tvalid,
    output logic                 rx_tready,
    input  tdata_t               rx_tdata,
    input  tbyte_t               rx_tkeep,
    input  tbyte_t               rx_tstrb,
    input  logic                 rx_tlast,
    input  tdest_t               rx_tdest,
    input  tuser_t               rx_tuser,
    input  tid_t                 rx_tid,
    // Transmit streams, one entry per output
    output logic   [OUTPUTS-1:0] tx_tvalid,
    input  logic   [OUTPUTS-1:0] tx_tready,
    output tdata_t [OUTPUTS-1:0] tx_tdata,
    output tbyte_t [OUTPUTS-1:0] tx_tkeep,
    output tbyte_t [OUTPUTS-1:0] tx_tstrb,
    output logic   [OUTPUTS-1:0] tx_tlast,
    output tdest_t [OUTPUTS-1:0] tx_tdest,
    output tuser_t [OUTPUTS-1:0] tx_tuser,
    output tid_t   [OUTPUTS-1:0] tx_tid
);
    logic   skid_tvalid;
    logic   skid_tready;
    tdata_t skid_tdata;
    tbyte_t skid_tkeep;
    tbyte_t skid_tstrb;
    logic   skid_tlast;
    tdest_t skid_tdest;
    tuser_t skid_tuser;
    tid_t   skid_tid;

    logic [OUTPUTS-1:0] route_tvalid;
    logic [OUTPUTS-1:0] route_tready;
    tdata_t             route_tdata;  // Payload is broadcast to every slice
    tbyte_t             route_tkeep;
    tbyte_t             route_tstrb;
    logic               route_tlast;
    tdest_t             route_tdest;
    tuser_t             route_tuser;
    tid_t               route_tid;

    axis_rx_skid u_skid (
        .aclk(aclk), .reset(reset),
        .in_tvalid(rx_tvalid), .in_tready(rx_tready), .in_tdata(rx_tdata),
        .in_tkeep(rx_tkeep), .in_tstrb(rx_tstrb), .in_tlast(rx_tlast),
        .in_tdest(rx_tdest), .in_tuser(rx_tuser), .in_tid(rx_tid),
        .out_tvalid(skid_tvalid), .out_tready(skid_tready), .out_tdata(skid_tdata),
        .out_tkeep(skid_tkeep), .out_tstrb(skid_tstrb), .out_tlast(skid_tlast),
        .out_tdest(skid_tdest), .out_tuser(skid_tuser), .out_tid(skid_tid)
    );

    axis_route_lookup #(
        .OUTPUTS(OUTPUTS),
        .USE_TID(USE_TID),
        .MAP(MAP)
    ) u_lookup (
        .aclk(aclk), .reset(reset),
        .in_tvalid(skid_tvalid), .in_tready(skid_tready), .in_tdata(skid_tdata),
        .in_tkeep(skid_tkeep), .in_tstrb(skid_tstrb), .in_tlast(skid_tlast),
        .in_tdest(skid_tdest), .in_tuser(skid_tuser), .in_tid(skid_tid),
        .out_tvalid(route_tvalid), .out_tready(route_tready), .out_tdata(route_tdata),
        .out_tkeep(route_tkeep), .out_tstrb(route_tstrb), .out_tlast(route_tlast),
        .out_tdest(route_tdest), .out_tuser(route_tuser), .out_tid(route_tid)
    );

    for (genvar k = 0; k < OUTPUTS; k++) begin : g_tx
        axis_tx_slice u_slice (
            .aclk(aclk), .reset(reset),
            .in_tvalid(route_tvalid[k]), .in_tready(route_tready[k]),
            .in_tdata(route_tdata), .in_tkeep(route_tkeep), .in_tstrb(route_tstrb),
            .in_tlast(route_tlast), .in_tdest(route_tdest), .in_tuser(route_tuser),
            .in_tid(route_tid),
            .out_tvalid(tx_tvalid[k]), .out_tready(tx_tready[k]),
            .out_tdata(tx_tdata[k]), .out_tkeep(tx_tkeep[k]), .out_tstrb(tx_tstrb[k]),
            .out_tlast(tx_tlast[k]), .out_tdest(tx_tdest[k]), .out_tuser(tx_tuser[k]),
            .out_tid(tx_tid[k])
        );
    end

endmodule

// File: source/axis_route_lookup.sv
`timescale 1ns/10ps

/* Route lookup between the skid buffer and the transmit slices.
 * Matches the first beat of each packet against MAP, locks the route until
 * tlast and consumes packets that match nothing. Purely combinational datapath.
 */
module axis_route_lookup import axis_demux_pkg::*; #(
    parameter int OUTPUTS = 4,
    parameter int USE_TID = 0,
    parameter logic [OUTPUTS-1:0][TUSER_WIDTH-1:0] MAP =
        (OUTPUTS * TUSER_WIDTH)'(map_default())
) (
    input  logic               aclk,
    input  logic               reset,
    // From the skid buffer
    input  logic               in_tvalid,
    output logic               in_tready,
    input  tdata_t             in_tdata,
    input  tbyte_t             in_tkeep,
    input  tbyte_t             in_tstrb,
    input  logic               in_tlast,
    input  tdest_t             in_tdest,
    input  tuser_t             in_tuser,
    input  tid_t               in_tid,
    // One valid per slice, payload shared by all of them
    output logic [OUTPUTS-1:0] out_tvalid,
    input  logic [OUTPUTS-1:0] out_tready,
    output tdata_t             out_tdata,
    output tbyte_t             out_tkeep,
    output tbyte_t             out_tstrb,
    output logic               out_tlast,
    output tdest_t             out_tdest,
    output tuser_t             out_tuser,
    output tid_t               out_tid
);
    localparam int IDX_W = $clog2(OUTPUTS);

    route_state_t     state;
    logic [IDX_W-1:0] lock_idx;
    logic [IDX_W-1:0] match_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             match_hit;
    logic             forward;
    logic             in_fire;
    tuser_t           route_field;

    // tid is zero extended to the table entry width
    assign route_field = (USE_TID != 0) ? tuser_t'(in_tid) : in_tuser;

    // Scan from the top so the lowest matching entry is left standing
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        for (int i = OUTPUTS - 1; i >= 0; i--) begin
            if (route_field == MAP[i]) begin
                match_hit = 1'b1;
                match_idx = IDX_W'(i);
            end
        end
    end

    assign forward = (state == ROUTE_FORWARD) || (state == ROUTE_IDLE && match_hit);
    assign sel_idx = (state == ROUTE_FORWARD) ? lock_idx : match_idx;

    always_comb begin
        for (int i = 0; i < OUTPUTS; i++) begin
            out_tvalid[i] = in_tvalid && forward && (sel_idx == IDX_W'(i));
        end
    end

    // Ready follows the selected slice, dropped beats always go through
    assign in_tready = forward ? out_tready[sel_idx] : 1'b1;
    assign in_fire   = in_tvalid && in_tready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state    <= ROUTE_IDLE;
            lock_idx <= '0;
        end else if (in_fire) begin
            case (state)
                ROUTE_IDLE: begin
                    if (!in_tlast) begin  // Single-beat packets need no lock
                        state    <= match_hit ? ROUTE_FORWARD : ROUTE_DROP;
                        lock_idx <= match_idx;
                    end
                end
                ROUTE_FORWARD, ROUTE_DROP: begin
                    if (in_tlast) begin
                        state <= ROUTE_IDLE;
                    end
                end
                default: state <= ROUTE_IDLE;
            endcase
        end
    end

    assign out_tdata = in_tdata;
    assign out_tkeep = in_tkeep;
    assign out_tstrb = in_tstrb;
    assign out_tlast = in_tlast;
    assign out_tdest = in_tdest;
    assign out_tuser = in_tuser;
    assign out_tid   = in_tid;

    assert property (@(posedge aclk) disable iff (reset) $onehot0(out_tvalid));

    // A locked route stays on the same real slice until its tlast beat goes through
    assert property (@(posedge aclk) disable iff (reset)
        state == ROUTE_FORWARD && !(in_fire && in_tlast)
            |=> state == ROUTE_FORWARD && $stable(lock_idx) && int'(lock_idx) < OUTPUTS);

endmodule

// File: source/axis_rx_skid.sv
`timescale 1ns/10ps

/* Input side of the demux. Two-entry skid buffer on the receive stream,
 * so the ready seen by the upstream source comes straight from a flop.
 */
module axis_rx_skid import axis_demux_pkg::*; (
    input  logic   aclk,
    input  logic   reset,
    // Receive side
    input  logic   in_tvalid,
    output logic   in_tready,
    input  tdata_t in_tdata,
    input  tbyte_t in_tkeep,
    input  tbyte_t in_tstrb,
    input  logic   in_tlast,
    input  tdest_t in_tdest,
    input  tuser_t in_tuser,
    input  tid_t   in_tid,
    // Towards the route lookup
    output logic   out_tvalid,
    input  logic   out_tready,
    output tdata_t out_tdata,
    output tbyte_t out_tkeep,
    output tbyte_t out_tstrb,
    output logic   out_tlast,
    output tdest_t out_tdest,
    output tuser_t out_tuser,
    output tid_t   out_tid
);
    beat_t in_beat;
    beat_t main_beat;
    beat_t spare_beat;
    logic  main_valid;
    logic  spare_valid;
    logic  in_fire;
    logic  out_fire;

    assign in_beat  = {in_tdata, in_tkeep, in_tstrb, in_tlast, in_tdest, in_tuser, in_tid};
    assign in_fire  = in_tvalid && in_tready;
    assign out_fire = main_valid && out_tready;

    // Only low while the spare holds a beat
    assign in_tready = ~spare_valid;

    always_ff @(posedge aclk) begin
        if (reset) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (spare_valid) begin
            if (out_fire) begin
                spare_valid <= 1'b0;  // Main refills from spare
            end
        end else if (in_fire) begin
            if (main_valid && !out_tready) begin
                spare_valid <= 1'b1;  // Late beat caught while main stalls
            end else begin
                main_valid <= 1'b1;
            end
        end else if (out_fire) begin
            main_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (spare_valid) begin
            if (out_fire) begin
                main_beat <= spare_beat;
            end
        end else if (in_fire) begin
            if (main_valid && !out_tready) begin
                spare_beat <= in_beat;
            end else begin
                main_beat <= in_beat;
            end
        end
    end

    assign out_tvalid = main_valid;
    assign {out_tdata, out_tkeep, out_tstrb, out_tlast, out_tdest, out_tuser, out_tid} = main_beat;

    // A stalled beat stays offered, unchanged, until the lookup takes it
    assert property (@(posedge aclk) disable iff (reset)
        out_tvalid && !out_tready |=> out_tvalid && $stable(main_beat));

endmodule

// File: source/axis_tx_slice.sv
`timescale 1ns/10ps

/* One-entry register slice in front of a single transmit stream.
 * Runs at full rate: it takes a new beat in the cycle the old one leaves.
 */
module axis_tx_slice import axis_demux_pkg::*; (
    input  logic   aclk,
    input  logic   reset,
    // From the route lookup
    input  logic   in_tvalid,
    output logic   in_tready,
    input  tdata_t in_tdata,
    input  tbyte_t in_tkeep,
    input  tbyte_t in_tstrb,
    input  logic   in_tlast,
    input  tdest_t in_tdest,
    input  tuser_t in_tuser,
    input  tid_t   in_tid,
    // Transmit side
    output logic   out_tvalid,
    input  logic   out_tready,
    output tdata_t out_tdata,
    output tbyte_t out_tkeep,
    output tbyte_t out_tstrb,
    output logic   out_tlast,
    output tdest_t out_tdest,
    output tuser_t out_tuser,
    output tid_t   out_tid
);
    beat_t in_beat;
    beat_t hold_beat;
    logic  hold_valid;
    logic  in_fire;

    assign in_beat = {in_tdata, in_tkeep, in_tstrb, in_tlast, in_tdest, in_tuser, in_tid};

    // Empty, or emptying in this very cycle
    assign in_tready = ~hold_valid || out_tready;
    assign in_fire   = in_tvalid && in_tready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (in_fire) begin
            hold_valid <= 1'b1;
        end else if (out_tready) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_fire) begin
            hold_beat <= in_beat;
        end
    end

    assign out_tvalid = hold_valid;
    assign {out_tdata, out_tkeep, out_tstrb, out_tlast, out_tdest, out_tuser, out_tid} = hold_beat;

    // Downstream may sample late, so a waiting beat must not change
    assert property (@(posedge aclk) disable iff (reset)
        out_tvalid && !out_tready |=> out_tvalid && $stable(hold_beat));

endmodule
